//--- run_sim.sh
#!/usr/bin/env bash
# Build the VGA framebuffer testbench with Verilator, run it and check the log.
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module vga_framebuffer_tb -f vga_framebuffer.f -o vga_framebuffer_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/vga_framebuffer_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q -x -F '*** PASSED ***' "$log"; then
  echo "testbench reported success"
  exit 0
fi

echo "pass message not found in $log"
exit 1

//--- vga_framebuffer.f
vga_pkg.sv
vga_timing.sv
vga_linebuf.sv
vga_framebuffer.sv
video_mem_model.sv
vga_framebuffer_tb.sv

//--- vga_framebuffer.sv
module vga_framebuffer
  import vga_pkg::*;
#(
  parameter int        h_active = 640,
  parameter int        h_front  = 16,
  parameter int        h_sync   = 96,
  parameter int        h_back   = 48,
  parameter int        v_active = 480,
  parameter int        v_front  = 10,
  parameter int        v_sync   = 2,
  parameter int        v_back   = 33,
  parameter bus_addr_t vidmem   = 32'h00c0_0000
) (
  input  logic        vga_clock,
  input  logic        reset_n,
  output logic        hs,
  output logic        vs,
  output logic        blank_n,
  output logic        bus_read,
  output bus_addr_t   address,
  input  logic [31:0] data,
  input  logic        bus_wait,
  output logic [7:0]  r,
  output logic [7:0]  g,
  output logic [7:0]  b
);

  localparam coord_t    h_last     = coord_t'(h_active + h_front + h_sync + h_back - 1);
  localparam coord_t    v_last     = coord_t'(v_active + v_front + v_sync + v_back - 1);
  localparam coord_t    line_words = coord_t'(h_active);
  localparam coord_t    last_row   = coord_t'(v_active - 1);
  localparam bus_addr_t row_bytes  = bus_addr_t'(4 * h_active);

  coord_t       x;
  coord_t       y;
  logic         active;
  logic         tim_hs;
  logic         tim_vs;
  logic         line_start;

  fetch_state_t fetch_state;
  coord_t       col;        // next word of the line to request.
  bus_addr_t    row_ptr;    // byte address of the row being fetched.
  logic         fetch_line;
  logic         fetch_bank;
  logic         disp_bank;

  logic         wr_en;
  coord_t       wr_addr;
  pixel_t       wr_data;
  pixel_t       q;

  // the last frame line loads row 0 and every active line but the last
  // loads the row after it, one line ahead of the display.
  assign fetch_line = line_start && ((y == v_last) || (y < last_row));

  assign bus_read = (fetch_state == fetch_request);
  assign address  = row_ptr + (bus_addr_t'(col) << 2);

  always_ff @(posedge vga_clock or negedge reset_n) begin
    if (!reset_n) begin
      fetch_state <= fetch_idle;
      col         <= '0;
      row_ptr     <= vidmem;
      fetch_bank  <= 1'b0;
      wr_en       <= 1'b0;
    end else begin
      wr_en <= 1'b0;
      case (fetch_state)
        fetch_idle: begin
          if (fetch_line) begin
            fetch_state <= fetch_request;
            fetch_bank  <= ~disp_bank;  // fill the bank that is hidden now.
            col         <= '0;
            if (y == v_last) begin
              row_ptr <= vidmem;  // frame wrap.
            end
          end
        end
        fetch_request: begin
          if (!bus_wait) begin
            wr_en       <= 1'b1;
            col         <= col + 1'b1;
            fetch_state <= fetch_release;
          end
        end
        fetch_release: begin
          if (col == line_words) begin
            row_ptr     <= row_ptr + row_bytes;
            fetch_state <= fetch_idle;
          end else begin
            fetch_state <= fetch_request;
          end
        end
        default: begin
          fetch_state <= fetch_idle;
        end
      endcase
    end
  end

  // the returned word is written to the line buffer in the release cycle.
  always_ff @(posedge vga_clock) begin
    if (bus_read && !bus_wait) begin
      wr_addr <= col;
      wr_data <= data[23:0];
    end
  end

  // banks swap as x wraps, so the first pixel of a line reads the new bank.
  always_ff @(posedge vga_clock or negedge reset_n) begin
    if (!reset_n) begin
      disp_bank <= 1'b0;
    end else if (x == h_last) begin
      disp_bank <= ~disp_bank;
    end
  end

  // one stage of delay on the controls to match the buffer read.
  always_ff @(posedge vga_clock or negedge reset_n) begin
    if (!reset_n) begin
      hs      <= 1'b1;
      vs      <= 1'b1;
      blank_n <= 1'b0;
    end else begin
      hs      <= tim_hs;
      vs      <= tim_vs;
      blank_n <= active;
    end
  end

  assign r = blank_n ? q[23:16] : 8'h00;
  assign g = blank_n ? q[15:8]  : 8'h00;
  assign b = blank_n ? q[7:0]   : 8'h00;

  vga_timing #(
    .h_active (h_active),
    .h_front  (h_front),
    .h_sync   (h_sync),
    .h_back   (h_back),
    .v_active (v_active),
    .v_front  (v_front),
    .v_sync   (v_sync),
    .v_back   (v_back)
  ) timing_i (
    .vga_clock  (vga_clock),
    .reset_n    (reset_n),
    .x          (x),
    .y          (y),
    .active     (active),
    .hs         (tim_hs),
    .vs         (tim_vs),
    .line_start (line_start)
  );

  vga_linebuf #(
    .h_active (h_active)
  ) linebuf_i (
    .vga_clock (vga_clock),
    .wr_en     (wr_en),
    .wr_bank   (fetch_bank),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_bank   (disp_bank),
    .rd_addr   (x),
    .q         (q)
  );

  address_held_in_wait: assert property (
    @(posedge vga_clock) disable iff (!reset_n)
    (bus_read && bus_wait) |=> $stable(address)
  ) else $error("bus address changed during a wait state.");

  // a line fetch has to finish within one line period.
  fetch_done_by_line_start: assert property (
    @(posedge vga_clock) disable iff (!reset_n)
    line_start |-> (fetch_state == fetch_idle)
  ) else $error("line fetch still running at line start.");

endmodule

//--- vga_framebuffer_tb.sv
module vga_framebuffer_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          h_active     = 16;
  localparam int          h_front      = 4;
  localparam int          h_sync       = 6;
  localparam int          h_back       = 46;
  localparam int          v_active     = 4;
  localparam int          v_front      = 1;
  localparam int          v_sync       = 2;
  localparam int          v_back       = 1;
  localparam int          h_total      = h_active + h_front + h_sync + h_back;
  localparam int          v_total      = v_active + v_front + v_sync + v_back;
  localparam int          frame_cycles = h_total * v_total;
  localparam int          frame_words  = h_active * v_active;
  localparam logic [31:0] vidmem       = 32'h00c0_0000;
  localparam logic [31:0] word_offset  = 32'h0055_aa00;

  localparam int sel_hs = 0;
  localparam int sel_vs = 1;

  logic        vga_clock = 1'b0;
  logic        reset_n;
  logic        hs;
  logic        vs;
  logic        blank_n;
  logic        bus_read;
  logic [31:0] address;
  logic [31:0] data;
  logic        bus_wait;
  logic [7:0]  r;
  logic [7:0]  g;
  logic [7:0]  b;
  int          wait_limit;

  int          errors   = 0;
  int          timeouts = 0;
  logic [31:0] accepted [$];  // addresses taken by the DUT in order.
  logic        prev_stall   = 1'b0;
  logic        prev_accept  = 1'b0;
  logic [31:0] prev_address = '0;

  always #5 vga_clock = ~vga_clock;

  vga_framebuffer #(
    .h_active (h_active),
    .h_front  (h_front),
    .h_sync   (h_sync),
    .h_back   (h_back),
    .v_active (v_active),
    .v_front  (v_front),
    .v_sync   (v_sync),
    .v_back   (v_back),
    .vidmem   (vidmem)
  ) dut_i (
    .vga_clock (vga_clock),
    .reset_n   (reset_n),
    .hs        (hs),
    .vs        (vs),
    .blank_n   (blank_n),
    .bus_read  (bus_read),
    .address   (address),
    .data      (data),
    .bus_wait  (bus_wait),
    .r         (r),
    .g         (g),
    .b         (b)
  );

  video_mem_model #(
    .pattern_offset (word_offset),
    .seed           (32'h24bb_8a1c)
  ) mem_i (
    .vga_clock  (vga_clock),
    .bus_read   (bus_read),
    .address    (address),
    .wait_limit (wait_limit),
    .data       (data),
    .bus_wait   (bus_wait)
  );

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    errors++;
    $display("MISMATCH at %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
  endtask

  function automatic logic pick_output(input int sel);
    return (sel == sel_hs) ? hs : vs;
  endfunction

  function automatic string output_name(input int sel);
    return (sel == sel_hs) ? "hs" : "vs";
  endfunction

  // expected colour of the nth visible pixel of a frame.
  function automatic logic [23:0] pixel_pattern(input int n);
    logic [31:0] word;
    word = vidmem + 32'(4 * n) + word_offset;
    return word[23:0];
  endfunction

  // counts falling edges until the output reaches level.
  task automatic wait_level(input int sel, input logic level, input int limit,
                            output int cycles, output bit ok);
    cycles = 0;
    ok     = 1'b1;
    while (pick_output(sel) !== level) begin
      @(negedge vga_clock);
      cycles++;
      if (cycles > limit) begin
        timeouts++;
        $display("timeout at %0t: %s did not reach %b within %0d cycles",
                 $time, output_name(sel), level, limit);
        ok = 1'b0;
        return;
      end
    end
  endtask

  task automatic wait_vs_fall(output bit ok);
    int cycles;
    wait_level(sel_vs, 1'b1, frame_cycles, cycles, ok);
    if (!ok) return;
    wait_level(sel_vs, 1'b0, frame_cycles, cycles, ok);
  endtask

  // low width and period of a sync pulse between two falling edges.
  task automatic measure_pulse(input int sel, input int limit, output int low,
                               output int period, output bit ok);
    int high;
    low    = 0;
    period = 0;
    wait_level(sel, 1'b1, limit, high, ok);
    if (!ok) return;
    wait_level(sel, 1'b0, limit, high, ok);
    if (!ok) return;
    wait_level(sel, 1'b1, limit, low, ok);
    if (!ok) return;
    wait_level(sel, 1'b0, limit, high, ok);
    period = low + high;
  endtask

  task automatic check_idle_outputs();
    assert (bus_read == 1'b0) else report_mismatch("bus_read", 0, 32'(bus_read));
    assert (blank_n == 1'b0) else report_mismatch("blank_n", 0, 32'(blank_n));
    assert (hs == 1'b1) else report_mismatch("hs", 1, 32'(hs));
    assert (vs == 1'b1) else report_mismatch("vs", 1, 32'(vs));
    assert ({r, g, b} == 24'h0) else report_mismatch("rgb", 0, 32'({r, g, b}));
    assert (address == vidmem) else report_mismatch("address", vidmem, address);
  endtask

  task automatic check_reset_state();
    repeat (2) begin
      @(negedge vga_clock);
      check_idle_outputs();
    end
    reset_n = 1'b1;  // the first line start is still one edge away.
    check_idle_outputs();
  endtask

  task automatic check_sync_timing();
    int  low;
    int  period;
    bit  ok;
    measure_pulse(sel_hs, h_total, low, period, ok);
    if (!ok) return;
    assert (low == h_sync) else report_mismatch("hs low cycles", h_sync, low);
    assert (period == h_total) else report_mismatch("hs period", h_total, period);
    measure_pulse(sel_vs, frame_cycles, low, period, ok);
    if (!ok) return;
    assert (low == v_sync * h_total) else report_mismatch("vs low cycles", v_sync * h_total, low);
    assert (period == frame_cycles) else report_mismatch("vs period", frame_cycles, period);
  endtask

  task automatic check_active_area();
    int run;
    int lines;
    bit ok;
    wait_vs_fall(ok);
    if (!ok) return;
    run   = 0;
    lines = 0;
    repeat (frame_cycles) begin
      @(negedge vga_clock);
      if (blank_n) begin
        run++;
      end else begin
        assert ({r, g, b} == 24'h0) else report_mismatch("rgb in blanking", 0, 32'({r, g, b}));
        if (run != 0) begin
          lines++;
          assert (run == h_active) else report_mismatch("blank_n high cycles", h_active, run);
          run = 0;
        end
      end
    end
    assert (lines == v_active) else report_mismatch("active lines", v_active, lines);
  endtask

  // two frames with no wait states; the second must start over at vidmem.
  task automatic check_address_sequence();
    logic [31:0] expected;
    bit          ok;
    wait_limit = 0;
    wait_vs_fall(ok);
    if (!ok) return;
    accepted.delete();
    repeat (2 * frame_cycles) @(negedge vga_clock);
    assert (accepted.size() == 2 * frame_words)
      else report_mismatch("accepted reads", 2 * frame_words, accepted.size());
    foreach (accepted[k]) begin
      expected = vidmem + 32'(4 * (k % frame_words));
      assert (accepted[k] == expected) else report_mismatch("address", expected, accepted[k]);
    end
  endtask

  task automatic check_pixels(input int limit);
    logic [23:0] expected;
    int          n;
    bit          ok;
    wait_vs_fall(ok);
    if (!ok) return;
    wait_limit = limit;  // row 0 of the next frame is fetched after this.
    n = 0;
    repeat (frame_cycles) begin
      @(negedge vga_clock);
      if (blank_n) begin
        expected = pixel_pattern(n);
        assert ({r, g, b} == expected) else report_mismatch("rgb", 32'(expected), 32'({r, g, b}));
        n++;
      end
    end
    assert (n == frame_words) else report_mismatch("visible pixels", frame_words, n);
  endtask

  // bus monitor. values read here are the ones the DUT saw at this edge.
  always @(posedge vga_clock) begin
    if (reset_n) begin
      if (prev_stall) begin
        assert (address == prev_address) else report_mismatch("address", prev_address, address);
      end
      if (prev_accept) begin
        assert (!bus_read) else begin
          errors++;
          $display("bus_read was not released after an accepted read at %0t", $time);
        end
      end
      if (bus_read && !bus_wait) begin
        accepted.push_back(address);
      end
      prev_stall   = bus_read && bus_wait;
      prev_accept  = bus_read && !bus_wait;
      prev_address = address;
    end else begin
      prev_stall  = 1'b0;
      prev_accept = 1'b0;
    end
  end

  task automatic finish_run();
    $display("check errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  initial begin
    reset_n    = 1'b0;
    wait_limit = 0;
    check_reset_state();
    check_sync_timing();
    check_active_area();
    check_address_sequence();
    check_pixels(0);
    check_pixels(2);  // stalls stay inside the line budget.
    finish_run();
  end

endmodule

//--- vga_linebuf.sv
module vga_linebuf
  import vga_pkg::*;
#(
  parameter int h_active = 640
) (
  input  logic   vga_clock,
  input  logic   wr_en,
  input  logic   wr_bank,
  input  coord_t wr_addr,
  input  pixel_t wr_data,
  input  logic   rd_bank,
  input  coord_t rd_addr,
  output pixel_t q
);

  localparam int depth = 2 * h_active;
  localparam int aw    = $clog2(depth);

  pixel_t        mem [depth];
  logic [aw-1:0] wr_index;
  logic [aw-1:0] rd_index;
  logic          rd_valid;

  // bank 1 sits directly above bank 0.
  assign wr_index = aw'(wr_addr) + (wr_bank ? aw'(h_active) : '0);
  assign rd_index = aw'(rd_addr) + (rd_bank ? aw'(h_active) : '0);

  assign rd_valid = (rd_addr < coord_t'(h_active));  // x runs past the line in blanking.

  always_ff @(posedge vga_clock) begin
    if (wr_en) begin
      mem[wr_index] <= wr_data;
    end
    if (rd_valid) begin
      q <= mem[rd_index];
    end
  end

  // a fetch still running when the banks swap would land in the shown line.
  no_write_to_display_bank: assert property (
    @(posedge vga_clock)
    wr_en |-> (wr_bank != rd_bank)
  ) else $error("line buffer write into the bank on display.");

endmodule

//--- vga_pkg.sv
package vga_pkg;

  // pixel and line counters wide enough for any common mode.
  typedef logic [11:0] coord_t;

  // packed colour with red in the top byte, then green, then blue.
  typedef logic [23:0] pixel_t;

  typedef logic [31:0] bus_addr_t;  // byte address on the read bus.

  // line fetch machine.
  // one word is requested per pass through request and release.
  typedef enum logic [1:0] {
    fetch_idle,      // waiting for the next line start.
    fetch_request,   // bus_read held until bus_wait drops.
    fetch_release    // one cycle with bus_read low.
  } fetch_state_t;

endpackage

//--- vga_timing.sv
module vga_timing
  import vga_pkg::*;
#(
  parameter int h_active = 640,
  parameter int h_front  = 16,
  parameter int h_sync   = 96,
  parameter int h_back   = 48,
  parameter int v_active = 480,
  parameter int v_front  = 10,
  parameter int v_sync   = 2,
  parameter int v_back   = 33
) (
  input  logic   vga_clock,
  input  logic   reset_n,
  output coord_t x,
  output coord_t y,
  output logic   active,
  output logic   hs,
  output logic   vs,
  output logic   line_start
);

  localparam coord_t h_total = coord_t'(h_active + h_front + h_sync + h_back);
  localparam coord_t v_total = coord_t'(v_active + v_front + v_sync + v_back);

  localparam coord_t h_visible = coord_t'(h_active);
  localparam coord_t v_visible = coord_t'(v_active);

  // sync windows open after active video plus front porch.
  localparam coord_t hs_begin = coord_t'(h_active + h_front);
  localparam coord_t hs_end   = coord_t'(h_active + h_front + h_sync);
  localparam coord_t vs_begin = coord_t'(v_active + v_front);
  localparam coord_t vs_end   = coord_t'(v_active + v_front + v_sync);

  coord_t x_next;
  coord_t y_next;
  logic   h_wrap;
  logic   v_wrap;

  assign h_wrap = (x == h_total - 1'b1);
  assign v_wrap = (y == v_total - 1'b1);

  always_comb begin
    x_next = x + 1'b1;
    y_next = y;
    if (h_wrap) begin
      x_next = '0;
      y_next = v_wrap ? '0 : y + 1'b1;
    end
  end

  // outputs are decoded from the next count so they line up with x and y.
  // reset parks the counters two lines before the frame start, so the
  // first line start lands on the line that fetches row 0.
  always_ff @(posedge vga_clock or negedge reset_n) begin
    if (!reset_n) begin
      x          <= h_total - 1'b1;
      y          <= v_total - 2'd2;
      active     <= 1'b0;
      hs         <= 1'b1;
      vs         <= 1'b1;
      line_start <= 1'b0;
    end else begin
      x          <= x_next;
      y          <= y_next;
      active     <= (x_next < h_visible) && (y_next < v_visible);
      hs         <= !((x_next >= hs_begin) && (x_next < hs_end));  // active low.
      vs         <= !((y_next >= vs_begin) && (y_next < vs_end));
      line_start <= h_wrap;
    end
  end

  // the sync pulse must sit entirely in the blanking interval.
  hs_outside_active: assert property (
    @(posedge vga_clock) disable iff (!reset_n)
    active |-> hs
  ) else $error("hs low during active video.");

endmodule

//--- video_mem_model.sv
module video_mem_model #(
  parameter logic [31:0] pattern_offset = 32'h0055_aa00,
  parameter logic [31:0] seed           = 32'h24bb_8a1c
) (
  input  logic        vga_clock,
  input  logic        bus_read,
  input  logic [31:0] address,
  input  int          wait_limit,
  output logic [31:0] data,
  output logic        bus_wait
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [31:0] lcg_state  = seed;
  logic [31:0] data_q     = '0;
  logic        wait_q     = 1'b0;
  logic        busy       = 1'b0;  // a request is open on the bus.
  int          waits_left = 0;

  assign data     = data_q;
  assign bus_wait = wait_q;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // the DUT samples on the rising edge, so the bus side moves on the falling one.
  always @(negedge vga_clock) begin
    if (bus_read) begin
      if (!busy) begin
        lcg_state  = lcg_next(lcg_state);  // a new request draws a new wait count.
        waits_left = int'(lcg_state[31:16]) % (wait_limit + 1);
        busy       = 1'b1;
      end
      data_q <= address + pattern_offset;
      if (waits_left > 0) begin
        wait_q <= 1'b1;
        waits_left--;
      end else begin
        wait_q <= 1'b0;
      end
    end else begin
      busy = 1'b0;
      wait_q <= 1'b0;
    end
  end

endmodule
